/* hw/sched_cfg_pkg.sv */
package sched_cfg_pkg;

	//////////////////////////////////////////////////
	// Default bus widths
	//////////////////////////////////////////////////
	localparam int ADDR_W_DEF = 32;  // Memory address
	localparam int DATA_W_DEF = 512; // One memory word, both sides
	localparam int PID_W_DEF  = 7;   // Processor id
	localparam int SLOT_W_DEF = 7;   // Slot id

	// DMA ids are one-hot and never zero
	localparam int NUM_DMA_DEF = 4;

	//////////////////////////////////////////////////
	// Buffering and DMA wait limit
	//////////////////////////////////////////////////
	localparam int QUEUE_DEPTH_DEF = 16;

	// Cycles a DMA request may wait before it wins over the queue
	localparam int DMA_TIMEOUT_DEF = 1023;

endpackage

/* hw/sched_types_pkg.sv */
package sched_types_pkg;

	// Source tag of a read sent to memory
	// Zero marks the command decoder, any other value is a DMA id
	localparam int SRC_LHS = 0;

	//////////////////////////////////////////////////
	// Occupancy statistic
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		OCC_IDLE        = 2'd0, // Nothing blocked
		OCC_RETURN_FULL = 2'd1, // Forwarding-unit return queue full
		OCC_MEM_BUSY    = 2'd2, // Memory not ready
		OCC_INPUT_FULL  = 2'd3  // Command-decoder queue full
	} occ_code_t;

endpackage

/* hw/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo import sched_cfg_pkg::*; #(
	parameter type payload_t = logic [DATA_W_DEF-1:0],
	parameter int  DEPTH     = QUEUE_DEPTH_DEF
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     i_push,
	input  payload_t i_din,
	input  logic     i_pop,
	output payload_t o_dout,
	output logic     o_empty,
	output logic     o_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nxt;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_pop  = i_pop & ~o_empty;
	assign do_push = i_push & (~o_full | do_pop); // A full FIFO still takes a push with a pop
	assign o_dout  = mem[rd_ptr];                 // First word falls through

	always_comb begin
		count_nxt = count;
		if (do_push && !do_pop) begin
			count_nxt = count + 1'b1;
		end else if (do_pop && !do_push) begin
			count_nxt = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			rd_ptr  <= '0;
			wr_ptr  <= '0;
			count   <= '0;
			o_empty <= 1'b1;
			o_full  <= 1'b0;
		end else begin
			if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
			if (do_push) wr_ptr <= ptr_inc(wr_ptr);
			count   <= count_nxt;
			o_empty <= (count_nxt == '0);
			o_full  <= (count_nxt == CNT_W'(DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= i_din;
	end

endmodule

/* hw/cd_request_queue.sv */
`timescale 1ns/100ps

module cd_request_queue import sched_cfg_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int PID_W  = PID_W_DEF,
	parameter int SLOT_W = SLOT_W_DEF,
	parameter int DEPTH  = QUEUE_DEPTH_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_cd_rd_en,
	input  logic              i_cd_wr_en,
	input  logic [PID_W-1:0]  i_cd_pid,
	input  logic [SLOT_W-1:0] i_cd_slot,
	input  logic [ADDR_W-1:0] i_cd_addr,
	input  logic [DATA_W-1:0] i_cd_data,
	input  logic              i_pop,
	output logic              o_cd_ready,
	output logic              o_valid,
	output logic              o_wr,
	output logic [PID_W-1:0]  o_pid,
	output logic [SLOT_W-1:0] o_slot,
	output logic [ADDR_W-1:0] o_addr,
	output logic [DATA_W-1:0] o_data,
	output logic              o_data_valid
);

	localparam int HDR_W = 1 + PID_W + SLOT_W + ADDR_W;

	logic [HDR_W-1:0] hdr_dout;
	logic             hdr_empty;
	logic             hdr_full;
	logic             data_empty;
	logic             data_full;

	// Header {wr, pid, slot, addr}, one per strobe
	sync_fifo #(.payload_t(logic [HDR_W-1:0]), .DEPTH(DEPTH)) u_hdr_fifo (
		.clk(clk), .rst(rst),
		.i_push(i_cd_rd_en | i_cd_wr_en),
		.i_din({i_cd_wr_en, i_cd_pid, i_cd_slot, i_cd_addr}),
		.i_pop(i_pop),
		.o_dout(hdr_dout), .o_empty(hdr_empty), .o_full(hdr_full)
	);

	// Write data only
	sync_fifo #(.payload_t(logic [DATA_W-1:0]), .DEPTH(DEPTH)) u_data_fifo (
		.clk(clk), .rst(rst),
		.i_push(i_cd_wr_en), .i_din(i_cd_data),
		.i_pop(i_pop & o_wr), // Reads leave the data FIFO alone
		.o_dout(o_data), .o_empty(data_empty), .o_full(data_full)
	);

	assign {o_wr, o_pid, o_slot, o_addr} = hdr_dout;
	assign o_valid      = ~hdr_empty;
	assign o_data_valid = ~data_empty;
	assign o_cd_ready   = ~(hdr_full | data_full);

endmodule

/* hw/dma_wait_timer.sv */
`timescale 1ns/100ps

module dma_wait_timer import sched_cfg_pkg::*; #(
	parameter int DMA_TIMEOUT = DMA_TIMEOUT_DEF
) (
	input  logic clk,
	input  logic rst,
	input  logic i_dma_valid,
	output logic o_timed_out
);

	localparam int CNT_W = $clog2(DMA_TIMEOUT + 1);

	logic [CNT_W-1:0] wait_cnt; // Cycles the current DMA request has been pending

	//////////////////////////////////////////////////
	// Wait counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst || !i_dma_valid) begin
			wait_cnt    <= '0;
			o_timed_out <= 1'b0;
		end else if (wait_cnt != CNT_W'(DMA_TIMEOUT)) begin
			wait_cnt <= wait_cnt + 1'b1;

			// Flag is seen after DMA_TIMEOUT pending cycles
			if (wait_cnt == CNT_W'(DMA_TIMEOUT - 1)) begin
				o_timed_out <= 1'b1;
			end
		end
		// Saturated count keeps the flag until the request drops
	end

endmodule

/* hw/mem_request_arbiter.sv */
`timescale 1ns/100ps

module mem_request_arbiter
	import sched_cfg_pkg::*;
	import sched_types_pkg::*;
#(
	parameter int ADDR_W  = ADDR_W_DEF,
	parameter int DATA_W  = DATA_W_DEF,
	parameter int NUM_DMA = NUM_DMA_DEF
) (
	// Queue head
	input  logic               i_q_valid,
	input  logic               i_q_wr,
	input  logic [ADDR_W-1:0]  i_q_addr,
	input  logic [DATA_W-1:0]  i_q_data,
	input  logic               i_q_data_valid,
	// DMA request and wait flag
	input  logic               i_dma_valid,
	input  logic               i_dma_wr,
	input  logic [ADDR_W-1:0]  i_dma_addr,
	input  logic [DATA_W-1:0]  i_dma_data,
	input  logic [NUM_DMA-1:0] i_dma_id,
	input  logic               i_dma_timed_out,
	// Back-pressure
	input  logic               i_mem_ready,
	input  logic               i_ret_full,
	// Decisions
	output logic               o_q_pop,
	output logic               o_dma_req_accept,
	output logic               o_mem_valid,
	output logic               o_mem_wr,
	output logic [ADDR_W-1:0]  o_mem_addr,
	output logic [DATA_W-1:0]  o_mem_data,
	output logic               o_tag_push,
	output logic [NUM_DMA-1:0] o_tag,
	output logic               o_hdr_push
);

	logic dma_urgent; // Timed-out DMA beats everything
	logic q_sel;      // Queue owns the port this cycle
	logic q_go;
	logic dma_go;

	//////////////////////////////////////////////////
	// Priority
	//////////////////////////////////////////////////
	assign dma_urgent = i_dma_valid & i_dma_timed_out;
	assign q_sel      = ~dma_urgent & i_q_valid & ~i_ret_full;

	// Queue write waits for its data and holds the port meanwhile
	assign q_go   = i_mem_ready & q_sel & (~i_q_wr | i_q_data_valid);
	assign dma_go = i_mem_ready & i_dma_valid & ~q_sel;

	assign o_q_pop          = q_go;
	assign o_dma_req_accept = dma_go;

	//////////////////////////////////////////////////
	// Memory request
	//////////////////////////////////////////////////
	assign o_mem_valid = q_go | dma_go;
	assign o_mem_wr    = dma_go ? i_dma_wr : (q_go & i_q_wr);
	assign o_mem_addr  = dma_go ? i_dma_addr : i_q_addr;
	assign o_mem_data  = dma_go ? i_dma_data : i_q_data;

	// Every read leaves a tag for its response
	assign o_tag_push = o_mem_valid & ~o_mem_wr;
	assign o_tag      = dma_go ? i_dma_id : NUM_DMA'(SRC_LHS);
	assign o_hdr_push = q_go & ~i_q_wr; // Header for the forwarding unit

endmodule

/* hw/mem_response_router.sv */
`timescale 1ns/100ps

module mem_response_router
	import sched_cfg_pkg::*;
	import sched_types_pkg::*;
#(
	parameter int DATA_W  = DATA_W_DEF,
	parameter int NUM_DMA = NUM_DMA_DEF,
	parameter int DEPTH   = QUEUE_DEPTH_DEF
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_tag_push,
	input  logic [NUM_DMA-1:0] i_tag,
	input  logic               i_mem_rsp_valid,
	input  logic [DATA_W-1:0]  i_mem_rsp_data,
	input  logic               i_dma_rsp_ready,
	input  logic               i_ret_data_full,
	output logic               o_mem_rsp_accept,
	output logic               o_dma_rsp_valid,
	output logic [NUM_DMA-1:0] o_dma_rsp_id,
	output logic [DATA_W-1:0]  o_dma_rsp_data,
	output logic               o_ret_data_push
);

	logic [NUM_DMA-1:0] tag_head;
	logic               tag_empty;
	logic               rsp_live; // Response with a known owner
	logic               to_dma;

	// Tags in request order, responses come back the same way
	sync_fifo #(.payload_t(logic [NUM_DMA-1:0]), .DEPTH(DEPTH)) u_tag_fifo (
		.clk(clk), .rst(rst),
		.i_push(i_tag_push), .i_din(i_tag),
		.i_pop(o_mem_rsp_accept),
		.o_dout(tag_head), .o_empty(tag_empty), .o_full()
	);

	assign rsp_live = i_mem_rsp_valid & ~tag_empty;
	assign to_dma   = (tag_head != NUM_DMA'(SRC_LHS));

	assign o_dma_rsp_valid  = rsp_live & to_dma & i_dma_rsp_ready;
	assign o_ret_data_push  = rsp_live & ~to_dma & ~i_ret_data_full;
	assign o_mem_rsp_accept = o_dma_rsp_valid | o_ret_data_push;

	assign o_dma_rsp_id   = tag_head;
	assign o_dma_rsp_data = i_mem_rsp_data;

endmodule

/* hw/fu_return_queue.sv */
`timescale 1ns/100ps

module fu_return_queue import sched_cfg_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int PID_W  = PID_W_DEF,
	parameter int SLOT_W = SLOT_W_DEF,
	parameter int DEPTH  = QUEUE_DEPTH_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_hdr_push,
	input  logic [PID_W-1:0]  i_pid,
	input  logic [SLOT_W-1:0] i_slot,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic              i_data_push,
	input  logic [DATA_W-1:0] i_data,
	input  logic              i_fu_ready,
	output logic              o_full,
	output logic              o_data_full,
	output logic              o_fu_valid,
	output logic [PID_W-1:0]  o_fu_pid,
	output logic [SLOT_W-1:0] o_fu_slot,
	output logic [ADDR_W-1:0] o_fu_addr,
	output logic [DATA_W-1:0] o_fu_data
);

	localparam int HDR_W = PID_W + SLOT_W + ADDR_W;

	logic fu_pop;
	logic hdr_full;
	logic data_empty;

	// Header is written at issue and always waits for its data
	assign fu_pop = o_fu_valid & i_fu_ready;

	sync_fifo #(.payload_t(logic [HDR_W-1:0]), .DEPTH(DEPTH)) u_hdr_fifo (
		.clk(clk), .rst(rst),
		.i_push(i_hdr_push), .i_din({i_pid, i_slot, i_addr}),
		.i_pop(fu_pop),
		.o_dout({o_fu_pid, o_fu_slot, o_fu_addr}), .o_empty(), .o_full(hdr_full)
	);

	sync_fifo #(.payload_t(logic [DATA_W-1:0]), .DEPTH(DEPTH)) u_data_fifo (
		.clk(clk), .rst(rst),
		.i_push(i_data_push), .i_din(i_data),
		.i_pop(fu_pop),
		.o_dout(o_fu_data), .o_empty(data_empty), .o_full(o_data_full)
	);

	assign o_fu_valid = ~data_empty;
	assign o_full     = hdr_full | o_data_full; // Stops new queue reads

endmodule

/* hw/mem_scheduler_top.sv */
`timescale 1ns/100ps

module mem_scheduler_top
	import sched_cfg_pkg::*;
	import sched_types_pkg::*;
#(
	parameter int ADDR_W      = ADDR_W_DEF,
	parameter int DATA_W      = DATA_W_DEF,
	parameter int PID_W       = PID_W_DEF,
	parameter int SLOT_W      = SLOT_W_DEF,
	parameter int NUM_DMA     = NUM_DMA_DEF,
	parameter int DEPTH       = QUEUE_DEPTH_DEF,
	parameter int DMA_TIMEOUT = DMA_TIMEOUT_DEF
) (
	input  logic               clk,
	input  logic               rst,
	// Command decoder
	input  logic               i_cd_rd_en,
	input  logic               i_cd_wr_en,
	input  logic [PID_W-1:0]   i_cd_pid,
	input  logic [SLOT_W-1:0]  i_cd_slot,
	input  logic [ADDR_W-1:0]  i_cd_addr,
	input  logic [DATA_W-1:0]  i_cd_data,
	output logic               o_cd_ready,
	// DMA requests and responses
	input  logic               i_dma_valid,
	input  logic               i_dma_wr,
	input  logic [ADDR_W-1:0]  i_dma_addr,
	input  logic [DATA_W-1:0]  i_dma_data,
	input  logic [NUM_DMA-1:0] i_dma_id,
	output logic               o_dma_req_accept,
	input  logic               i_dma_rsp_ready,
	output logic               o_dma_rsp_valid,
	output logic [NUM_DMA-1:0] o_dma_rsp_id,
	output logic [DATA_W-1:0]  o_dma_rsp_data,
	// Memory port
	input  logic               i_mem_ready,
	output logic               o_mem_valid,
	output logic               o_mem_wr,
	output logic [ADDR_W-1:0]  o_mem_addr,
	output logic [DATA_W-1:0]  o_mem_data,
	input  logic               i_mem_rsp_valid,
	input  logic [DATA_W-1:0]  i_mem_rsp_data,
	output logic               o_mem_rsp_accept,
	// Forwarding unit
	input  logic               i_fu_ready,
	output logic               o_fu_valid,
	output logic [DATA_W-1:0]  o_fu_data,
	output logic [PID_W-1:0]   o_fu_pid,
	output logic [SLOT_W-1:0]  o_fu_slot,
	output logic [ADDR_W-1:0]  o_fu_addr,
	output occ_code_t          o_occupancy
);

	logic               q_valid, q_wr, q_data_valid, q_pop;
	logic [PID_W-1:0]   q_pid;
	logic [SLOT_W-1:0]  q_slot;
	logic [ADDR_W-1:0]  q_addr;
	logic [DATA_W-1:0]  q_data;
	logic               dma_timed_out;
	logic               tag_push, hdr_push;
	logic [NUM_DMA-1:0] tag;
	logic               ret_full, ret_data_full, ret_data_push;

	cd_request_queue #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .PID_W(PID_W), .SLOT_W(SLOT_W),
		.DEPTH(DEPTH)) u_cd_queue (
		.clk(clk), .rst(rst), .i_cd_rd_en(i_cd_rd_en), .i_cd_wr_en(i_cd_wr_en),
		.i_cd_pid(i_cd_pid), .i_cd_slot(i_cd_slot), .i_cd_addr(i_cd_addr),
		.i_cd_data(i_cd_data), .i_pop(q_pop), .o_cd_ready(o_cd_ready),
		.o_valid(q_valid), .o_wr(q_wr), .o_pid(q_pid), .o_slot(q_slot),
		.o_addr(q_addr), .o_data(q_data), .o_data_valid(q_data_valid)
	);

	dma_wait_timer #(.DMA_TIMEOUT(DMA_TIMEOUT)) u_dma_timer (
		.clk(clk), .rst(rst), .i_dma_valid(i_dma_valid), .o_timed_out(dma_timed_out)
	);

	mem_request_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .NUM_DMA(NUM_DMA)) u_arbiter (
		.i_q_valid(q_valid), .i_q_wr(q_wr), .i_q_addr(q_addr), .i_q_data(q_data),
		.i_q_data_valid(q_data_valid), .i_dma_valid(i_dma_valid), .i_dma_wr(i_dma_wr),
		.i_dma_addr(i_dma_addr), .i_dma_data(i_dma_data), .i_dma_id(i_dma_id),
		.i_dma_timed_out(dma_timed_out), .i_mem_ready(i_mem_ready), .i_ret_full(ret_full),
		.o_q_pop(q_pop), .o_dma_req_accept(o_dma_req_accept), .o_mem_valid(o_mem_valid),
		.o_mem_wr(o_mem_wr), .o_mem_addr(o_mem_addr), .o_mem_data(o_mem_data),
		.o_tag_push(tag_push), .o_tag(tag), .o_hdr_push(hdr_push)
	);

	mem_response_router #(.DATA_W(DATA_W), .NUM_DMA(NUM_DMA), .DEPTH(DEPTH)) u_router (
		.clk(clk), .rst(rst), .i_tag_push(tag_push), .i_tag(tag),
		.i_mem_rsp_valid(i_mem_rsp_valid), .i_mem_rsp_data(i_mem_rsp_data),
		.i_dma_rsp_ready(i_dma_rsp_ready), .i_ret_data_full(ret_data_full),
		.o_mem_rsp_accept(o_mem_rsp_accept), .o_dma_rsp_valid(o_dma_rsp_valid),
		.o_dma_rsp_id(o_dma_rsp_id), .o_dma_rsp_data(o_dma_rsp_data),
		.o_ret_data_push(ret_data_push)
	);

	fu_return_queue #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .PID_W(PID_W), .SLOT_W(SLOT_W),
		.DEPTH(DEPTH)) u_return_queue (
		.clk(clk), .rst(rst), .i_hdr_push(hdr_push), .i_pid(q_pid), .i_slot(q_slot),
		.i_addr(q_addr), .i_data_push(ret_data_push), .i_data(i_mem_rsp_data),
		.i_fu_ready(i_fu_ready), .o_full(ret_full), .o_data_full(ret_data_full),
		.o_fu_valid(o_fu_valid), .o_fu_pid(o_fu_pid), .o_fu_slot(o_fu_slot),
		.o_fu_addr(o_fu_addr), .o_fu_data(o_fu_data)
	);

	//////////////////////////////////////////////////
	// Occupancy statistic, first blocking cause wins
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			o_occupancy <= OCC_IDLE;
		end else if (!o_cd_ready) begin
			o_occupancy <= OCC_INPUT_FULL;
		end else if (!i_mem_ready) begin
			o_occupancy <= OCC_MEM_BUSY;
		end else if (ret_full) begin
			o_occupancy <= OCC_RETURN_FULL;
		end else begin
			o_occupancy <= OCC_IDLE;
		end
	end

endmodule

/* verif/tb_mem_scheduler.sv */
`timescale 1ns/100ps

module tb_mem_scheduler import sched_types_pkg::*; ();

	localparam int TIMEOUT = 15;
	localparam int NROWS   = 10;

	typedef enum logic [2:0] {CD_READ, CD_WRITE, DMA_READ, DMA_WRITE, STALL_MEM, STALL_FU} kind_t;
	typedef struct packed {
		kind_t       kind;
		logic [31:0] addr;
		logic [63:0] data;
		logic [6:0]  pid;
		logic [6:0]  slot;
		logic [3:0]  id;
		logic [7:0]  n_bg;  // Queue reads loaded before the DMA request
		logic [7:0]  hold;  // Memory stall cycles after the DMA request rises
		logic [7:0]  exp;   // Queue reads expected on the bus ahead of the DMA
	} row_t;
	typedef struct packed {
		logic [6:0]  pid;
		logic [6:0]  slot;
		logic [31:0] addr;
		logic [63:0] data;
	} ret_t;

	logic clk, rst;
	logic i_cd_rd_en, i_cd_wr_en;
	logic [6:0] i_cd_pid, i_cd_slot;
	logic [31:0] i_cd_addr, i_dma_addr, o_mem_addr, o_fu_addr;
	logic [63:0] i_cd_data, i_dma_data, o_dma_rsp_data, o_mem_data, i_mem_rsp_data, o_fu_data;
	logic o_cd_ready, i_dma_valid, i_dma_wr, o_dma_req_accept, i_dma_rsp_ready, o_dma_rsp_valid;
	logic [3:0] i_dma_id, o_dma_rsp_id;
	logic i_mem_ready, o_mem_valid, o_mem_wr, i_mem_rsp_valid, o_mem_rsp_accept;
	logic i_fu_ready, o_fu_valid;
	logic [6:0] o_fu_pid, o_fu_slot;
	occ_code_t o_occupancy;

	row_t        rows [NROWS];
	ret_t        fu_exp [$];         // Reads owed to the forwarding unit, in order
	logic [63:0] exp_mem [logic [31:0]];
	logic [63:0] mem_arr [logic [31:0]];
	int          rsp_due [$];
	logic [63:0] rsp_data [$];
	logic        rsp_taken;
	logic [31:0] last_wr_addr;
	logic [63:0] last_wr_data;
	logic [31:0] seed;
	int          cyc, wr_cnt, errors, n_pass, n_fail;

	mem_scheduler_top #(.ADDR_W(32), .DATA_W(64), .PID_W(7), .SLOT_W(7), .NUM_DMA(4),
		.DEPTH(4), .DMA_TIMEOUT(TIMEOUT)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	// Word returned for an address never written
	function automatic logic [63:0] mix(input logic [31:0] a);
		return {a, ~a} ^ 64'h9e37_79b9_7f4a_7c15;
	endfunction

	function automatic logic [63:0] exp_data(input logic [31:0] a);
		return exp_mem.exists(a) ? exp_mem[a] : mix(a);
	endfunction

	task automatic check(input logic [63:0] act, input logic [63:0] exp, input string msg);
		if (act !== exp) begin
			$display("ERROR %0t: %s got %0h expected %0h", $time, msg, act, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model, three cycles per read, in order
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		rsp_taken = o_mem_rsp_accept;
		if (rst && o_mem_valid && i_mem_ready) begin
			if (o_mem_wr) begin
				mem_arr[o_mem_addr] = o_mem_data;
				last_wr_addr = o_mem_addr;
				last_wr_data = o_mem_data;
				wr_cnt++;
			end else begin
				rsp_due.push_back(cyc + 3);
				rsp_data.push_back(mem_arr.exists(o_mem_addr) ? mem_arr[o_mem_addr] :
					mix(o_mem_addr));
			end
		end
	end

	always @(posedge clk) begin
		if (rsp_taken && rsp_due.size() != 0) begin
			void'(rsp_due.pop_front());
			void'(rsp_data.pop_front());
		end
		if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
			i_mem_rsp_valid <= 1'b1;
			i_mem_rsp_data  <= rsp_data[0];
		end else begin
			i_mem_rsp_valid <= 1'b0;
		end
	end

	// Forwarding-unit returns against the owed list
	always @(negedge clk) begin
		if (rst && o_fu_valid && i_fu_ready) begin
			if (fu_exp.size() == 0) begin
				$display("ERROR %0t: forwarding unit returned data nobody asked for", $time);
				errors++;
			end else begin
				check(64'(o_fu_pid), 64'(fu_exp[0].pid), "fu pid");
				check(64'(o_fu_slot), 64'(fu_exp[0].slot), "fu slot");
				check(64'(o_fu_addr), 64'(fu_exp[0].addr), "fu addr");
				check(o_fu_data, fu_exp[0].data, "fu data");
				void'(fu_exp.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= NROWS * 200) begin
			$display("Timeout: the tests did not finish within %0d cycles", NROWS * 200);
			$display("Simulation FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////
	task automatic cd_strobe(input logic wr, input logic [31:0] addr, input logic [63:0] data,
		input logic [6:0] pid, input logic [6:0] slot);
		@(negedge clk);
		while (!o_cd_ready) @(negedge clk);
		@(posedge clk);
		i_cd_rd_en <= ~wr;
		i_cd_wr_en <= wr;
		i_cd_addr  <= addr;
		i_cd_data  <= data;
		i_cd_pid   <= pid;
		i_cd_slot  <= slot;
		@(posedge clk);
		i_cd_rd_en <= 1'b0;
		i_cd_wr_en <= 1'b0;
		if (wr) exp_mem[addr] = data;
		else fu_exp.push_back({pid, slot, addr, exp_data(addr)});
	endtask

	task automatic wait_fu_drained();
		while (fu_exp.size() != 0) @(negedge clk);
	endtask

	task automatic dma_request(input row_t r);
		int n;
		int waited;
		if (r.n_bg != 0) begin
			@(posedge clk);
			i_mem_ready <= 1'b0;
			for (int k = 0; k < int'(r.n_bg); k++)
				cd_strobe(1'b0, r.addr + 32'(k * 8 + 64), '0, r.pid + 7'(k), r.slot);
		end
		@(posedge clk);
		i_dma_valid <= 1'b1;
		i_dma_wr    <= (r.kind == DMA_WRITE);
		i_dma_addr  <= r.addr;
		i_dma_data  <= r.data;
		i_dma_id    <= r.id;
		repeat (int'(r.hold)) @(posedge clk);
		i_mem_ready <= 1'b1;
		n = 0;
		waited = 0;
		@(negedge clk);
		while (!o_dma_req_accept) begin
			if (o_mem_valid && i_mem_ready) n++;
			waited++;
			@(negedge clk);
		end
		check(64'(n), 64'(r.exp), "queue requests ahead of DMA");
		check(64'(waited <= TIMEOUT + int'(r.n_bg) + int'(r.hold) + 2), 64'd1, "DMA wait bound");
		check(64'(o_mem_addr), 64'(r.addr), "DMA memory address");
		check(64'(o_mem_wr), 64'(r.kind == DMA_WRITE), "DMA memory write flag");
		if (r.kind == DMA_WRITE) begin
			check(o_mem_data, r.data, "DMA write data");
			exp_mem[r.addr] = r.data;
		end
		@(posedge clk);
		i_dma_valid <= 1'b0;
		if (r.kind == DMA_READ) begin
			@(negedge clk);
			while (!o_dma_rsp_valid) @(negedge clk);
			check(64'(o_dma_rsp_id), 64'(r.id), "DMA response id");
			check(o_dma_rsp_data, exp_data(r.addr), "DMA response data");
		end
	endtask

	task automatic run_row(input row_t r);
		int n0;
		case (r.kind)
			CD_WRITE: begin
				n0 = wr_cnt;
				cd_strobe(1'b1, r.addr, r.data, r.pid, r.slot);
				while (wr_cnt == n0) @(negedge clk);
				check(64'(last_wr_addr), 64'(r.addr), "write address");
				check(last_wr_data, r.data, "write data");
				repeat (6) @(negedge clk);
				check(64'(wr_cnt), 64'(n0 + 1), "writes on the bus");
			end
			CD_READ: cd_strobe(1'b0, r.addr, '0, r.pid, r.slot);
			STALL_MEM: begin
				@(posedge clk);
				i_mem_ready <= 1'b0;
				for (int k = 0; k < 4; k++)
					cd_strobe(1'b0, r.addr + 32'(k * 8), '0, r.pid + 7'(k), r.slot);
				@(negedge clk);
				check(64'(o_cd_ready), 64'd0, "ready with a full queue");
				@(negedge clk);
				check(64'(o_occupancy), 64'(OCC_INPUT_FULL), "occupancy with a full queue");
				@(posedge clk);
				i_mem_ready <= 1'b1;
				cd_strobe(1'b0, r.addr + 32'd32, '0, r.pid + 7'd4, r.slot);
			end
			STALL_FU: begin
				@(posedge clk);
				i_fu_ready <= 1'b0;
				// Fifth read waits in the queue behind the full return queue
				for (int k = 0; k < 5; k++)
					cd_strobe(1'b0, r.addr + 32'(k * 8), '0, r.pid + 7'(k), r.slot);
				repeat (20) begin
					@(negedge clk);
					if (o_occupancy == OCC_RETURN_FULL) break;
				end
				check(64'(o_occupancy), 64'(OCC_RETURN_FULL), "occupancy with return queue full");
				dma_request('{kind: DMA_READ, addr: r.addr + 32'h80, data: '0, pid: '0,
					slot: '0, id: r.id, n_bg: '0, hold: '0, exp: '0});
				@(posedge clk);
				i_fu_ready <= 1'b1;
			end
			default: dma_request(r);
		endcase
		wait_fu_drained();
	endtask

	task automatic add_row(input int i, input kind_t kind, input logic [31:0] addr,
		input logic [3:0] id, input logic [7:0] n_bg, input logic [7:0] hold, input logic [7:0] exp);
		logic [31:0] hi;
		seed = xorshift(seed);
		hi = seed;
		seed = xorshift(seed);
		rows[i] = '{kind: kind, addr: addr, data: {hi, seed}, pid: 7'(i + 3), slot: 7'(2 * i + 1),
			id: id, n_bg: n_bg, hold: hold, exp: exp};
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		int e0;
		rst = 1'b0;
		{i_cd_rd_en, i_cd_wr_en, i_dma_valid, i_dma_wr, i_mem_rsp_valid} = '0;
		{i_cd_pid, i_cd_slot, i_cd_addr, i_cd_data} = '0;
		{i_dma_addr, i_dma_data, i_dma_id, i_mem_rsp_data} = '0;
		{i_mem_ready, i_dma_rsp_ready, i_fu_ready} = 3'b111;
		{cyc, wr_cnt, errors, n_pass, n_fail} = '0;
		rsp_taken = 1'b0;
		seed = 32'h52c3_2da9;

		add_row(0, CD_WRITE,  32'h100, 4'd0, 8'd0, 8'd0,  8'd0);
		add_row(1, CD_READ,   32'h100, 4'd0, 8'd0, 8'd0,  8'd0);
		add_row(2, CD_READ,   32'h200, 4'd0, 8'd0, 8'd0,  8'd0);
		add_row(3, DMA_WRITE, 32'h300, 4'd2, 8'd0, 8'd0,  8'd0);
		add_row(4, DMA_READ,  32'h300, 4'd4, 8'd0, 8'd0,  8'd0);
		add_row(5, DMA_READ,  32'h104, 4'd1, 8'd4, 8'd0,  8'd4); // Queue drains first
		add_row(6, DMA_READ,  32'h108, 4'd8, 8'd4, 8'd20, 8'd0); // Timed out, DMA first
		add_row(7, STALL_MEM, 32'h400, 4'd0, 8'd0, 8'd0,  8'd0);
		add_row(8, STALL_FU,  32'h500, 4'd2, 8'd0, 8'd0,  8'd0);
		add_row(9, CD_READ,   32'h300, 4'd0, 8'd0, 8'd0,  8'd0);

		repeat (4) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check(64'(o_cd_ready), 64'd1, "ready after reset");
		check(64'(o_occupancy), 64'(OCC_IDLE), "occupancy after reset");

		for (int i = 0; i < NROWS; i++) begin
			e0 = errors;
			run_row(rows[i]);
			if (errors == e0) n_pass++;
			else n_fail++;
			$display("test %0d %s: %s", i, rows[i].kind.name(), (errors == e0) ? "ok" : "failed");
		end

		repeat (10) @(negedge clk);
		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
hw/sched_cfg_pkg.sv
hw/sched_types_pkg.sv
hw/sync_fifo.sv
hw/cd_request_queue.sv
hw/dma_wait_timer.sv
hw/mem_request_arbiter.sv
hw/mem_response_router.sv
hw/fu_return_queue.sv
hw/mem_scheduler_top.sv
verif/tb_mem_scheduler.sv

/* Makefile */
TOP = tb_mem_scheduler

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)
	verilator --lint-only -f project.f --top-module mem_scheduler_top

clean:
	rm -rf obj_dir sim.log
